// File: all.f
design/mips_isa_pkg.sv
design/lsu_bus_pkg.sv
design/lsu_access_if.sv
design/lsu_req_decode.sv
design/load_align.sv
design/lsu_sequencer.sv
design/mem_access_top.sv
verif/wb_ram_model.sv
verif/tb_mem_access.sv

// File: Bender.yml
package:
  name: mem_access

sources:
  - design/mips_isa_pkg.sv
  - design/lsu_bus_pkg.sv
  - design/lsu_access_if.sv
  - design/lsu_req_decode.sv
  - design/load_align.sv
  - design/lsu_sequencer.sv
  - design/mem_access_top.sv
  - target: test
    files:
      - verif/wb_ram_model.sv
      - verif/tb_mem_access.sv

// File: verif/tb_mem_access.sv
/*
 * Testbench for the load/store unit.
 * Random loads and stores against a shadow memory, link bit, errors and back-pressure.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_access;

    localparam int wait_limit = 20;

    logic                                clk;
    logic                                arst_n_i;
    logic                                req_valid_i;
    mips_isa_pkg::lsu_op_e               req_op_i;
    logic [lsu_bus_pkg::adr_w-1:0]       req_addr_i;
    logic [mips_isa_pkg::word_w-1:0]     req_reg2_i;
    logic                                req_ready_o;
    logic                                rsp_valid_o;
    logic [mips_isa_pkg::word_w-1:0]     rsp_data_o;
    logic                                rsp_err_o;
    logic                                wb_cyc_o;
    logic                                wb_stb_o;
    logic                                wb_we_o;
    logic [lsu_bus_pkg::adr_w-1:0]       wb_adr_o;
    logic [lsu_bus_pkg::sel_w-1:0]       wb_sel_o;
    logic [lsu_bus_pkg::dat_w-1:0]       wb_dat_o;
    logic [lsu_bus_pkg::dat_w-1:0]       wb_dat_i;
    logic                                wb_ack_i;
    logic [1:0]                          ack_delay;
    logic [31:0]                         rng;
    logic [31:0]                         shadow [0:63];
    logic                                link;
    int                                  errs;
    int                                  timeouts;

    mem_access_top mem_access_top_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_reg2_i  (req_reg2_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o),
        .rsp_err_o   (rsp_err_o),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_sel_o    (wb_sel_o),
        .wb_dat_o    (wb_dat_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i)
    );

    wb_ram_model wb_ram_model_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .cyc_i    (wb_cyc_o),
        .stb_i    (wb_stb_o),
        .we_i     (wb_we_o),
        .adr_i    (wb_adr_o),
        .sel_i    (wb_sel_o),
        .dat_i    (wb_dat_o),
        .delay_i  (ack_delay),
        .dat_o    (wb_dat_i),
        .ack_o    (wb_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // lane 0 is the most significant byte
    function automatic logic [7:0] lane(input logic [31:0] w, input int k);
        return w[31-8*k -: 8];
    endfunction

    function automatic logic [31:0] apply_store(input logic [31:0] w,
                                                input mips_isa_pkg::lsu_op_e op,
                                                input int n, input logic [31:0] rt);
        logic [31:0] r;
        int          k;
        int          src;
        r = w;
        for (k = 0; k < 4; k++) begin
            case (op)
                mips_isa_pkg::op_sb:  src = (k == n) ? 3 : -1;
                mips_isa_pkg::op_sh:  src = (k == n || k == n + 1) ? k - n + 2 : -1;
                mips_isa_pkg::op_swl: src = (k >= n) ? k - n : -1;
                mips_isa_pkg::op_swr: src = (k <= n) ? k + 3 - n : -1;
                default:              src = k; // sw, sc
            endcase
            if (src >= 0) begin
                r[31-8*k -: 8] = lane(rt, src);
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] load_value(input logic [31:0] w,
                                               input mips_isa_pkg::lsu_op_e op,
                                               input int n, input logic [31:0] rt);
        logic [31:0] r;
        logic [7:0]  b;
        logic [15:0] h;
        int          k;
        b = lane(w, n);
        h = {lane(w, n & 2), lane(w, (n & 2) + 1)};
        r = rt;
        case (op)
            mips_isa_pkg::op_lb:  r = {{24{b[7]}}, b};
            mips_isa_pkg::op_lbu: r = {24'd0, b};
            mips_isa_pkg::op_lh:  r = {{16{h[15]}}, h};
            mips_isa_pkg::op_lhu: r = {16'd0, h};
            mips_isa_pkg::op_lwl: begin
                for (k = 0; k <= 3 - n; k++) begin
                    r[31-8*k -: 8] = lane(w, k + n);
                end
            end
            mips_isa_pkg::op_lwr: begin
                for (k = 3 - n; k < 4; k++) begin
                    r[31-8*k -: 8] = lane(w, k - 3 + n);
                end
            end
            default: r = w; // lw, ll
        endcase
        return r;
    endfunction

    function automatic mips_isa_pkg::lsu_op_e pick_store(input logic [31:0] r);
        case (r % 5)
            0:       return mips_isa_pkg::op_sb;
            1:       return mips_isa_pkg::op_sh;
            2:       return mips_isa_pkg::op_sw;
            3:       return mips_isa_pkg::op_swl;
            default: return mips_isa_pkg::op_swr;
        endcase
    endfunction

    function automatic mips_isa_pkg::lsu_op_e pick_load(input logic [31:0] r);
        case (r % 6)
            0:       return mips_isa_pkg::op_lb;
            1:       return mips_isa_pkg::op_lbu;
            2:       return mips_isa_pkg::op_lh;
            3:       return mips_isa_pkg::op_lhu;
            4:       return mips_isa_pkg::op_lwl;
            default: return mips_isa_pkg::op_lwr;
        endcase
    endfunction

    task automatic roll(output logic [31:0] r);
        rng = xorshift(rng);
        r = rng;
    endtask

    // called on a falling edge
    task automatic put_req(input mips_isa_pkg::lsu_op_e op, input logic [31:0] addr,
                           input logic [31:0] rt, input logic [1:0] dly);
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_addr_i  = addr;
        req_reg2_i  = rt;
        ack_delay   = dly;
    endtask

    task automatic wait_accept();
        int waits;
        waits = 0;
        while (!req_ready_o && waits < wait_limit) begin
            @(negedge clk);
            waits++;
        end
        if (!req_ready_o) begin
            $display("Timeout: request was not accepted within %0d cycles", wait_limit);
            timeouts++;
        end else begin
            @(posedge clk);
            @(negedge clk);
        end
        req_valid_i = 1'b0;
    endtask

    task automatic wait_rsp(output logic [31:0] data, output logic err,
                            output logic bus, output int waits);
        waits = 0;
        bus   = 1'b0;
        while (!rsp_valid_o && waits < wait_limit) begin
            if (wb_cyc_o) begin
                bus = 1'b1;
            end
            @(negedge clk);
            waits++;
        end
        if (!rsp_valid_o) begin
            $display("Timeout: no response within %0d cycles", wait_limit);
            timeouts++;
        end
        data = rsp_data_o;
        err  = rsp_err_o;
    endtask

    task automatic do_req(input mips_isa_pkg::lsu_op_e op, input logic [31:0] addr,
                          input logic [31:0] rt, input logic [31:0] exp_data,
                          input logic exp_err, input logic exp_bus);
        logic [31:0] r;
        logic [31:0] got;
        logic        got_err;
        logic        bus;
        int          waits;
        roll(r);
        put_req(op, addr, rt, r[1:0]);
        wait_accept();
        wait_rsp(got, got_err, bus, waits);
        if (bus !== exp_bus) begin
            $display("Fail at %0t: op %0d addr %h bus cycle %b, expected %b",
                     $time, op, addr, bus, exp_bus);
            errs++;
        end
        if (!exp_bus && waits != 0) begin
            $display("Fail at %0t: op %0d response %0d cycles late", $time, op, waits);
            errs++;
        end
        if (got_err !== exp_err) begin
            $display("Fail at %0t: op %0d addr %h err %b, expected %b",
                     $time, op, addr, got_err, exp_err);
            errs++;
        end
        if (!exp_err && got !== exp_data) begin
            $display("Fail at %0t: op %0d addr %h rt %h data %h, expected %h",
                     $time, op, addr, rt, got, exp_data);
            errs++;
        end
    endtask

    task automatic load_word(input mips_isa_pkg::lsu_op_e op, input logic [31:0] a,
                             input logic [31:0] rt);
        logic [31:0] exp_val;
        exp_val = load_value(shadow[a[7:2]], op, a[1:0], rt);
        do_req(op, a, rt, exp_val, 1'b0, 1'b1);
        if (op == mips_isa_pkg::op_ll) begin
            link = 1'b1;
        end
    endtask

    task automatic store_word(input mips_isa_pkg::lsu_op_e op, input logic [31:0] a,
                              input logic [31:0] rt);
        do_req(op, a, rt, 32'd0, 1'b0, 1'b1);
        shadow[a[7:2]] = apply_store(shadow[a[7:2]], op, a[1:0], rt);
    endtask

    task automatic store_cond(input logic [31:0] a, input logic [31:0] rt);
        do_req(mips_isa_pkg::op_sc, a, rt, {31'd0, link}, 1'b0, link);
        if (link) begin
            shadow[a[7:2]] = apply_store(shadow[a[7:2]], mips_isa_pkg::op_sc, a[1:0], rt);
            link = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (wb_cyc_o === 1'b1 && wb_adr_o[1:0] !== 2'b00) begin
            $display("Fail at %0t: wishbone address %h not word aligned", $time, wb_adr_o);
            errs++;
        end
        if (wb_stb_o !== wb_cyc_o) begin
            $display("Fail at %0t: wb_stb_o %b differs from wb_cyc_o %b",
                     $time, wb_stb_o, wb_cyc_o);
            errs++;
        end
        if (wb_we_o === 1'b1 && wb_cyc_o !== 1'b1) begin
            $display("Fail at %0t: wb_we_o high outside a bus cycle", $time);
            errs++;
        end
    end

    initial begin
        logic [31:0]           r;
        logic [31:0]           a;
        logic [31:0]           rt;
        logic [31:0]           got;
        logic                  got_err;
        logic                  bus;
        int                    waits;
        int                    i;
        mips_isa_pkg::lsu_op_e op;
        $timeformat(-9, 0, " ns", 0);
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_op_i    = mips_isa_pkg::op_lw;
        req_addr_i  = '0;
        req_reg2_i  = '0;
        ack_delay   = 2'd0;
        rng         = 32'hb53dcb77;
        link        = 1'b0;
        errs        = 0;
        timeouts    = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        if (req_ready_o !== 1'b1 || wb_cyc_o !== 1'b0 || rsp_valid_o !== 1'b0) begin
            $display("Fail at %0t: idle state wrong after reset", $time);
            errs++;
        end

        for (i = 0; i < 64; i++) begin
            roll(rt);
            store_word(mips_isa_pkg::op_sw, i * 4, rt); // known contents
        end
        for (i = 0; i < 48; i++) begin
            roll(r);
            op = pick_store(r);
            roll(a);
            a = {24'd0, a[7:0]};
            if (op == mips_isa_pkg::op_sh) begin
                a[0] = 1'b0;
            end
            roll(rt);
            store_word(op, a, rt);
            load_word(mips_isa_pkg::op_lw, {a[31:2], 2'b00}, 32'd0);
        end
        for (i = 0; i < 64; i++) begin
            roll(r);
            op = pick_load(r);
            roll(a);
            a = {24'd0, a[7:0]};
            if (op == mips_isa_pkg::op_lh || op == mips_isa_pkg::op_lhu) begin
                a[0] = 1'b0;
            end
            roll(rt);
            load_word(op, a, rt);
        end

        // link bit
        roll(rt);
        store_cond(32'h40, rt);
        load_word(mips_isa_pkg::op_lw, 32'h40, 32'd0);
        load_word(mips_isa_pkg::op_ll, 32'h40, 32'd0);
        store_cond(32'h40, rt);
        load_word(mips_isa_pkg::op_lw, 32'h40, 32'd0);
        store_cond(32'h40, ~rt);
        load_word(mips_isa_pkg::op_lw, 32'h40, 32'd0);

        // odd halfwords and illegal codes
        do_req(mips_isa_pkg::op_lh, 32'h21, rt, 32'd0, 1'b1, 1'b0);
        do_req(mips_isa_pkg::op_lhu, 32'h23, rt, 32'd0, 1'b1, 1'b0);
        do_req(mips_isa_pkg::op_sh, 32'h25, rt, 32'd0, 1'b1, 1'b0);
        load_word(mips_isa_pkg::op_lw, 32'h24, 32'd0);
        do_req(mips_isa_pkg::lsu_op_e'(4'd14), 32'h30, rt, 32'd0, 1'b1, 1'b0);
        do_req(mips_isa_pkg::lsu_op_e'(4'd15), 32'h30, rt, 32'd0, 1'b1, 1'b0);
        load_word(mips_isa_pkg::op_lw, 32'h30, 32'd0);

        // second request held valid behind a slow read
        put_req(mips_isa_pkg::op_lw, 32'h10, 32'd0, 2'd3);
        wait_accept();
        put_req(mips_isa_pkg::op_lw, 32'h14, 32'd0, 2'd3);
        waits = 0;
        while (!rsp_valid_o && waits < wait_limit) begin
            if (req_ready_o) begin
                $display("Fail at %0t: req_ready_o high before the response", $time);
                errs++;
            end
            @(negedge clk);
            waits++;
        end
        if (!rsp_valid_o) begin
            $display("Timeout: first response of the held request pair never came");
            timeouts++;
        end else if (rsp_data_o !== shadow[4]) begin
            $display("Fail at %0t: first read %h, expected %h", $time, rsp_data_o, shadow[4]);
            errs++;
        end
        wait_accept();
        wait_rsp(got, got_err, bus, waits);
        if (got !== shadow[5] || got_err !== 1'b0) begin
            $display("Fail at %0t: held read %h, expected %h", $time, got, shadow[5]);
            errs++;
        end

        @(negedge clk);
        $display("errors: %0d, timeouts: %0d", errs, timeouts);
        if (errs == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/wb_ram_model.sv
/*
 * Wishbone classic slave RAM of 64 words.
 * Big-endian byte-select writes, ack after 0 to 3 wait cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module wb_ram_model (
    input  wire logic        clk,
    input  wire logic        arst_n_i,
    input  wire logic        cyc_i,
    input  wire logic        stb_i,
    input  wire logic        we_i,
    input  wire logic [31:0] adr_i,
    input  wire logic [3:0]  sel_i,
    input  wire logic [31:0] dat_i,
    input  wire logic [1:0]  delay_i,
    output logic [31:0]      dat_o,
    output logic             ack_o
);

    logic [31:0] mem [0:63];
    logic [1:0]  wait_q;
    logic [5:0]  idx;
    logic [31:0] mask;
    int          i;

    assign idx   = adr_i[7:2];
    assign dat_o = mem[idx];
    assign ack_o = cyc_i & stb_i & (wait_q >= delay_i);
    assign mask  = {{8{sel_i[3]}}, {8{sel_i[2]}}, {8{sel_i[1]}}, {8{sel_i[0]}}}; // sel_i[3] is 31:24

    initial begin
        for (i = 0; i < 64; i++) begin
            mem[i] = 32'h6b8b4567 ^ (i * 32'h01000193); // every word differs
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_q <= 2'd0;
        end else if (cyc_i && stb_i && !ack_o) begin
            wait_q <= wait_q + 2'd1;
        end else begin
            wait_q <= 2'd0;
        end
    end

    always @(posedge clk) begin
        if (ack_o && we_i) begin
            mem[idx] <= (mem[idx] & ~mask) | (dat_i & mask);
        end
    end

endmodule

`default_nettype wire

// File: design/mem_access_top.sv
/*
 * Load/store unit top level.
 * Decoder, sequencer and load aligner behind plain request and Wishbone ports.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_access_top (
    input  wire logic                                clk,
    input  wire logic                                arst_n_i,
    input  wire logic                                req_valid_i,
    input  wire mips_isa_pkg::lsu_op_e               req_op_i,
    input  wire logic [lsu_bus_pkg::adr_w-1:0]       req_addr_i,
    input  wire logic [mips_isa_pkg::word_w-1:0]     req_reg2_i,
    output logic                                     req_ready_o,
    output logic                                     rsp_valid_o,
    output logic [mips_isa_pkg::word_w-1:0]          rsp_data_o,
    output logic                                     rsp_err_o,
    output logic                                     wb_cyc_o,
    output logic                                     wb_stb_o,
    output logic                                     wb_we_o,
    output logic [lsu_bus_pkg::adr_w-1:0]            wb_adr_o,
    output logic [lsu_bus_pkg::sel_w-1:0]            wb_sel_o,
    output logic [lsu_bus_pkg::dat_w-1:0]            wb_dat_o,
    input  wire logic [lsu_bus_pkg::dat_w-1:0]       wb_dat_i,
    input  wire logic                                wb_ack_i
);

    mips_isa_pkg::lsu_op_e              held_op;
    logic [1:0]                         held_offset;
    logic [mips_isa_pkg::word_w-1:0]    held_reg2;
    logic [lsu_bus_pkg::dat_w-1:0]      held_word;
    logic [mips_isa_pkg::word_w-1:0]    load_data;

    lsu_access_if acc_if ();

    lsu_req_decode lsu_req_decode_inst (
        .op_i   (req_op_i),
        .addr_i (req_addr_i),
        .reg2_i (req_reg2_i),
        .acc    (acc_if.dec)
    );

    lsu_sequencer lsu_sequencer_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .op_i        (req_op_i),
        .addr_i      (req_addr_i),
        .reg2_i      (req_reg2_i),
        .acc         (acc_if.seq),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_sel_o    (wb_sel_o),
        .wb_dat_o    (wb_dat_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i),
        .load_data_i (load_data),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o),
        .rsp_err_o   (rsp_err_o),
        .op_o        (held_op),
        .offset_o    (held_offset),
        .reg2_o      (held_reg2),
        .word_o      (held_word)
    );

    load_align load_align_inst (
        .op_i     (held_op),
        .offset_i (held_offset),
        .word_i   (held_word),
        .reg2_i   (held_reg2),
        .data_o   (load_data)
    );

endmodule

`default_nettype wire

// File: design/lsu_sequencer.sv
/*
 * Load/store sequencer.
 * Accepts requests, runs one Wishbone classic cycle, holds the link bit
 * and presents the response.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_sequencer (
    input  wire logic                                clk,
    input  wire logic                                arst_n_i,
    input  wire logic                                req_valid_i,
    output logic                                     req_ready_o,
    input  wire mips_isa_pkg::lsu_op_e               op_i,
    input  wire logic [lsu_bus_pkg::adr_w-1:0]       addr_i,
    input  wire logic [mips_isa_pkg::word_w-1:0]     reg2_i,
    lsu_access_if.seq                                acc,
    output logic                                     wb_cyc_o,
    output logic                                     wb_stb_o,
    output logic                                     wb_we_o,
    output logic [lsu_bus_pkg::adr_w-1:0]            wb_adr_o,
    output logic [lsu_bus_pkg::sel_w-1:0]            wb_sel_o,
    output logic [lsu_bus_pkg::dat_w-1:0]            wb_dat_o,
    input  wire logic [lsu_bus_pkg::dat_w-1:0]       wb_dat_i,
    input  wire logic                                wb_ack_i,
    input  wire logic [mips_isa_pkg::word_w-1:0]     load_data_i,
    output logic                                     rsp_valid_o,
    output logic [mips_isa_pkg::word_w-1:0]          rsp_data_o,
    output logic                                     rsp_err_o,
    output mips_isa_pkg::lsu_op_e                    op_o,
    output logic [1:0]                               offset_o,
    output logic [mips_isa_pkg::word_w-1:0]          reg2_o,
    output logic [lsu_bus_pkg::dat_w-1:0]            word_o
);

    logic [1:0]                         state_q;
    logic                               accept;
    logic                               go_bus;
    logic                               ack;
    logic [lsu_bus_pkg::adr_w-1:0]      adr_q;
    logic [lsu_bus_pkg::sel_w-1:0]      sel_q;
    logic [lsu_bus_pkg::dat_w-1:0]      dat_q;
    logic                               we_q;
    logic                               err_q;
    logic                               ll_set_q;
    logic                               sc_ok_q;
    logic                               link_q;

    assign req_ready_o = (state_q == lsu_bus_pkg::st_idle) || (state_q == lsu_bus_pkg::st_rsp);
    assign accept      = req_valid_i & req_ready_o;
    assign go_bus      = acc.needs_bus & (~acc.sc | link_q); // failed sc skips the bus
    assign ack         = (state_q == lsu_bus_pkg::st_bus) & wb_ack_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= lsu_bus_pkg::st_idle;
        end else if (state_q == lsu_bus_pkg::st_bus) begin
            if (wb_ack_i) begin
                state_q <= lsu_bus_pkg::st_rsp;
            end
        end else if (accept) begin
            state_q <= go_bus ? lsu_bus_pkg::st_bus : lsu_bus_pkg::st_rsp;
        end else begin
            state_q <= lsu_bus_pkg::st_idle;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            we_q     <= 1'b0;
            err_q    <= 1'b0;
            ll_set_q <= 1'b0;
            sc_ok_q  <= 1'b0;
        end else if (accept) begin
            we_q     <= acc.we;
            err_q    <= acc.err;
            ll_set_q <= acc.ll_set;
            sc_ok_q  <= acc.sc & link_q;
        end
    end

    // link bit changes only when the bus cycle completes
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            link_q <= 1'b0;
        end else if (ack) begin
            if (ll_set_q) begin
                link_q <= 1'b1;
            end else if (sc_ok_q) begin
                link_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            adr_q    <= acc.adr;
            sel_q    <= acc.sel;
            dat_q    <= acc.dat;
            op_o     <= op_i;
            offset_o <= addr_i[1:0];
            reg2_o   <= reg2_i;
        end
        if (ack) begin
            word_o <= wb_dat_i; // read data for the aligner
        end
    end

    assign wb_cyc_o = (state_q == lsu_bus_pkg::st_bus);
    assign wb_stb_o = wb_cyc_o;
    assign wb_we_o  = wb_cyc_o & we_q;
    assign wb_adr_o = adr_q;
    assign wb_sel_o = sel_q;
    assign wb_dat_o = dat_q;

    assign rsp_valid_o = (state_q == lsu_bus_pkg::st_rsp);
    assign rsp_err_o   = rsp_valid_o & err_q;

    always_comb begin
        if (err_q) begin
            rsp_data_o = '0;
        end else if (op_o == mips_isa_pkg::op_sc) begin
            rsp_data_o = {{(mips_isa_pkg::word_w-1){1'b0}}, sc_ok_q};
        end else if (we_q) begin
            rsp_data_o = '0; // plain stores
        end else begin
            rsp_data_o = load_data_i;
        end
    end

endmodule

`default_nettype wire

// File: design/load_align.sv
/*
 * Load data aligner.
 * Extracts, extends or merges the loaded word into the write-back value.
 */
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire mips_isa_pkg::lsu_op_e             op_i,
    input  wire logic [1:0]                        offset_i,
    input  wire logic [lsu_bus_pkg::dat_w-1:0]     word_i,
    input  wire logic [mips_isa_pkg::word_w-1:0]   reg2_i,
    output logic [mips_isa_pkg::word_w-1:0]        data_o
);

    lsu_bus_pkg::mem_word_u             wd;
    logic [7:0]                         b;
    logic [15:0]                        h;
    logic [4:0]                         lsh;
    logic [4:0]                         rsh;
    logic [mips_isa_pkg::word_w-1:0]    keep_lo;
    logic [mips_isa_pkg::word_w-1:0]    keep_hi;

    assign wd      = word_i;
    assign b       = wd.bytes[offset_i];
    assign h       = wd.halves[offset_i[1]];
    assign lsh     = {offset_i, 3'b000};  // 8n
    assign rsh     = {~offset_i, 3'b000}; // 8(3-n)
    assign keep_lo = ~({(mips_isa_pkg::word_w){1'b1}} << lsh); // low rt bytes
    assign keep_hi = ~({(mips_isa_pkg::word_w){1'b1}} >> rsh); // high rt bytes

    always_comb begin
        case (op_i)
            mips_isa_pkg::op_lb:  data_o = {{24{b[7]}}, b};
            mips_isa_pkg::op_lbu: data_o = {24'b0, b};
            mips_isa_pkg::op_lh:  data_o = {{16{h[15]}}, h};
            mips_isa_pkg::op_lhu: data_o = {16'b0, h};
            mips_isa_pkg::op_lw, mips_isa_pkg::op_ll: begin
                data_o = wd.word;
            end
            mips_isa_pkg::op_lwl: begin
                data_o = (wd.word << lsh) | (reg2_i & keep_lo);
            end
            mips_isa_pkg::op_lwr: begin
                data_o = (wd.word >> rsh) | (reg2_i & keep_hi);
            end
            default: data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/lsu_req_decode.sv
/*
 * Load/store request decoder.
 * Maps operation, address and rt to byte selects, store data and link effect.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_req_decode (
    input  wire mips_isa_pkg::lsu_op_e                 op_i,
    input  wire logic [lsu_bus_pkg::adr_w-1:0]         addr_i,
    input  wire logic [mips_isa_pkg::word_w-1:0]       reg2_i,
    lsu_access_if.dec                                  acc
);

    logic [1:0]                    n;
    logic [lsu_bus_pkg::sel_w-1:0] sel;
    logic [lsu_bus_pkg::dat_w-1:0] dat;
    logic                          we;
    logic                          needs_bus;
    logic                          err;
    logic                          ll_set;
    logic                          sc;
    logic [lsu_bus_pkg::sel_w-1:0] half_sel;
    logic [4:0]                    lsh;
    logic [4:0]                    rsh;

    assign n        = addr_i[1:0];
    assign half_sel = n[1] ? 4'b0011 : 4'b1100;
    assign lsh      = {n, 3'b000};  // 8n
    assign rsh      = {~n, 3'b000}; // 8(3-n)

    always_comb begin
        sel       = '0;
        dat       = '0;
        we        = 1'b0;
        needs_bus = 1'b1;
        err       = 1'b0;
        ll_set    = 1'b0;
        sc        = 1'b0;
        case (op_i)
            mips_isa_pkg::op_lb, mips_isa_pkg::op_lbu: begin
                sel = 4'b1000 >> n;
            end
            mips_isa_pkg::op_sb: begin
                sel = 4'b1000 >> n;
                dat = {4{reg2_i[7:0]}};
                we  = 1'b1;
            end
            mips_isa_pkg::op_lh, mips_isa_pkg::op_lhu: begin
                if (n[0]) begin
                    needs_bus = 1'b0; // odd halfword
                    err       = 1'b1;
                end else begin
                    sel = half_sel;
                end
            end
            mips_isa_pkg::op_sh: begin
                if (n[0]) begin
                    needs_bus = 1'b0;
                    err       = 1'b1;
                end else begin
                    sel = half_sel;
                    dat = {2{reg2_i[15:0]}};
                    we  = 1'b1;
                end
            end
            mips_isa_pkg::op_lw, mips_isa_pkg::op_lwl, mips_isa_pkg::op_lwr: begin
                sel = 4'b1111; // merge happens on the way back
            end
            mips_isa_pkg::op_ll: begin
                sel    = 4'b1111;
                ll_set = 1'b1;
            end
            mips_isa_pkg::op_sw: begin
                sel = 4'b1111;
                dat = reg2_i;
                we  = 1'b1;
            end
            mips_isa_pkg::op_sc: begin
                sel = 4'b1111;
                dat = reg2_i;
                we  = 1'b1;
                sc  = 1'b1; // sequencer checks the link bit
            end
            mips_isa_pkg::op_swl: begin
                sel = 4'b1111 >> n;
                dat = reg2_i >> lsh;
                we  = 1'b1;
            end
            mips_isa_pkg::op_swr: begin
                sel = 4'b1111 << ~n;
                dat = reg2_i << rsh;
                we  = 1'b1;
            end
            default: begin
                needs_bus = 1'b0; // unknown code
                err       = 1'b1;
            end
        endcase
    end

    assign acc.adr       = {addr_i[lsu_bus_pkg::adr_w-1:2], 2'b00};
    assign acc.sel       = sel;
    assign acc.dat       = dat;
    assign acc.we        = we;
    assign acc.needs_bus = needs_bus;
    assign acc.err       = err;
    assign acc.ll_set    = ll_set;
    assign acc.sc        = sc;

endmodule

`default_nettype wire

// File: design/lsu_access_if.sv
/*
 * Decoded access bundle.
 * Carries one bus access from the request decoder to the sequencer.
 */
`timescale 1ns/1ps
`default_nettype none

interface lsu_access_if;

    logic [lsu_bus_pkg::adr_w-1:0] adr; // word aligned
    logic [lsu_bus_pkg::sel_w-1:0] sel;
    logic [lsu_bus_pkg::dat_w-1:0] dat;
    logic                          we;
    logic                          needs_bus;
    logic                          err;
    logic                          ll_set;
    logic                          sc;

    modport dec (
        output adr, sel, dat, we, needs_bus, err, ll_set, sc
    );

    modport seq (
        input adr, sel, dat, we, needs_bus, err, ll_set, sc
    );

endinterface

`default_nettype wire

// File: design/lsu_bus_pkg.sv
/*
 * Data bus definitions for the load/store unit.
 * Bus widths, sequencer states and the big-endian data word views.
 */
`default_nettype none

package lsu_bus_pkg;

    localparam int unsigned adr_w = 32;
    localparam int unsigned dat_w = 32;
    localparam int unsigned sel_w = dat_w / 8; // one select per byte

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_bus  = 2'd1; // wishbone cycle open
    localparam logic [1:0] st_rsp  = 2'd2;

    typedef union packed {
        logic [dat_w-1:0]            word;
        logic [0:sel_w-1][7:0]       bytes;  // bytes[0] is bits 31:24
        logic [0:1][dat_w/2-1:0]     halves; // halves[0] is bits 31:16
    } mem_word_u;

endpackage

`default_nettype wire

// File: design/mips_isa_pkg.sv
/*
 * MIPS ISA definitions for the load/store unit.
 * Register word width and the memory operation codes.
 */
`default_nettype none

package mips_isa_pkg;

    localparam int unsigned word_w = 32; // gpr width

    // memory operations as seen by the load/store unit
    typedef enum logic [3:0] {
        op_lb  = 4'd0,
        op_lbu = 4'd1,
        op_lh  = 4'd2,
        op_lhu = 4'd3,
        op_lw  = 4'd4,
        op_lwl = 4'd5,
        op_lwr = 4'd6,
        op_sb  = 4'd7,
        op_sh  = 4'd8,
        op_sw  = 4'd9,
        op_swl = 4'd10,
        op_swr = 4'd11,
        op_ll  = 4'd12,
        op_sc  = 4'd13  // 14 and 15 are illegal
    } lsu_op_e;

endpackage

`default_nettype wire
